//--- common/fpga_regs_pkg.sv
// FPGA realtime register block, shared definitions
// Widths, register map, version word and the TRNG word layout
package fpga_regs_pkg;

    // Bus and payload widths
    localparam int DATA_W           = 32;
    localparam int ADDR_W           = 8;
    localparam int CHAR_W           = 8;
    localparam int NIBBLE_W         = 4;
    localparam int NIBBLES_PER_WORD = 8;

    // Register map, word aligned byte offsets
    localparam logic [ADDR_W-1:0] REG_VERSION       = 8'h00;
    localparam logic [ADDR_W-1:0] REG_CONTROL       = 8'h04;
    localparam logic [ADDR_W-1:0] REG_ITRNG_DIVISOR = 8'h08;
    localparam logic [ADDR_W-1:0] REG_CYCLE_COUNT   = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_LOG_DATA      = 8'h10; // Char in 7:0, valid in 8
    localparam logic [ADDR_W-1:0] REG_LOG_STATUS    = 8'h14; // Empty in 0, full in 1
    localparam logic [ADDR_W-1:0] REG_ITRNG_DATA    = 8'h18; // Write only
    localparam logic [ADDR_W-1:0] REG_ITRNG_STATUS  = 8'h1C; // Empty in 0, full in 1

    // Control register bits
    localparam int CTRL_ITRNG_RST_BIT = 0;

    // Log data register layout
    localparam int LOG_VALID_BIT = CHAR_W;

    // Returned by REG_VERSION
    localparam logic [DATA_W-1:0] FPGA_VERSION = 32'h0001_0400;

    // One TRNG entropy word
    // Written over APB as a whole word, handed to the core as nibbles,
    // lowest nibble first
    typedef union packed {
        logic [DATA_W-1:0]                         word;
        logic [NIBBLES_PER_WORD-1:0][NIBBLE_W-1:0] nibbles;
    } itrng_word_u;

endpackage

//--- common/reg_bus_if.sv
// Internal register access bus
// One single-cycle access per req, read data and error returned combinationally
`timescale 1ns/1ps

interface reg_bus_if
    import fpga_regs_pkg::*;
();

    logic              req;   // One cycle per transfer
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              err;   // Unmapped offset

    modport master (
        output req, we, addr, wdata,
        input  rdata, err
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, err
    );

endinterface

//--- logic/sync_fifo.sv
// Synchronous first-word-fall-through FIFO
// Head entry is visible on rdata while not empty, write when full and
// read when empty are ignored
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             core_clk,
    input  logic             hwif_out,
    input  logic             srst,     // Synchronous clear
    input  logic             wr,
    input  logic [WIDTH-1:0] wdata,
    input  logic             rd,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (do_wr && !srst) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

endmodule

//--- logic/itrng_fifo.sv
// Internal TRNG FIFO
// Stores whole entropy words and hands them to the core one nibble per
// grant, lowest nibble first, popping the word after its last nibble
`timescale 1ns/1ps

module itrng_fifo
    import fpga_regs_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic                core_clk,
    input  logic                hwif_out,
    input  logic                srst,
    input  logic                push,
    input  itrng_word_u         word,
    input  logic                grant,
    output logic [NIBBLE_W-1:0] nibble,
    output logic                nibble_valid,
    output logic                empty,
    output logic                full
);

    localparam int IDX_W = $clog2(NIBBLES_PER_WORD);

    logic [DATA_W-1:0] head_data;
    itrng_word_u       head;
    logic [IDX_W-1:0]  idx;       // Next nibble of the head word
    logic              take;
    logic              pop;

    sync_fifo #(
        .WIDTH (DATA_W),
        .DEPTH (DEPTH)
    ) word_fifo_i (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .srst     (srst),
        .wr       (push),
        .wdata    (word.word),
        .rd       (pop),
        .rdata    (head_data),
        .empty    (empty),
        .full     (full)
    );

    always_comb begin
        head.word = head_data;
    end

    // Grants with nothing stored are dropped
    assign take = grant && !empty && !srst;
    assign pop  = take && (idx == IDX_W'(NIBBLES_PER_WORD - 1));

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            idx          <= '0;
            nibble_valid <= 1'b0;
        end else if (srst) begin
            idx          <= '0;
            nibble_valid <= 1'b0;
        end else begin
            nibble_valid <= take;
            if (take) begin
                idx <= idx + 1'b1;  // Wraps to 0 with the pop
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (take) begin
            nibble <= head.nibbles[idx];
        end
    end

endmodule

//--- logic/itrng_throttle.sv
// TRNG request throttle
// Reloading down-counter, lets one request through each time it hits zero
`timescale 1ns/1ps

module itrng_throttle
    import fpga_regs_pkg::*;
(
    input  logic              core_clk,
    input  logic              hwif_out,
    input  logic              req,
    input  logic [DATA_W-1:0] divisor,
    output logic              grant
);

    logic [DATA_W-1:0] count;

    // Period is divisor + 1 cycles
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            count <= '0;
            grant <= 1'b0;
        end else if (count == '0) begin
            count <= divisor;
            grant <= req;   // Sample the core request
        end else begin
            count <= count - 1'b1;
            grant <= 1'b0;
        end
    end

endmodule

//--- apb_regs/apb_slave_fsm.sv
// APB slave state machine
// Tracks setup and access phases, captures the transfer in setup and
// issues one register access per transfer with zero wait states
`timescale 1ns/1ps

module apb_slave_fsm
    import fpga_regs_pkg::*;
(
    input  logic              core_clk,
    input  logic              hwif_out,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    reg_bus_if.master         bus
);

    localparam logic [1:0] IDLE   = 2'd0;
    localparam logic [1:0] SETUP  = 2'd1;
    localparam logic [1:0] ACCESS = 2'd2;

    logic [1:0] state;  // Phase seen in the previous cycle
    logic [1:0] phase;  // Phase of the current cycle

    // Access only directly after a captured setup
    always_comb begin
        phase = IDLE;
        case (state)
            SETUP: begin
                if (psel && penable) begin
                    phase = ACCESS;
                end else if (psel) begin
                    phase = SETUP;
                end
            end
            default: begin
                if (psel && !penable) begin
                    phase = SETUP;
                end
            end
        endcase
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            state <= IDLE;
        end else begin
            state <= phase;
        end
    end

    // Transfer capture
    always_ff @(posedge core_clk) begin
        if (phase == SETUP) begin
            bus.addr  <= paddr;
            bus.we    <= pwrite;
            bus.wdata <= pwdata;
        end
    end

    assign bus.req = (phase == ACCESS);

    assign pready  = (phase == ACCESS);
    assign pslverr = (phase == ACCESS) && bus.err;
    assign prdata  = (phase == ACCESS) ? bus.rdata : '0;

endmodule

//--- apb_regs/fpga_realtime_regs.sv
// FPGA realtime register file
// Decodes register accesses, holds control, divisor and cycle counter,
// and turns reads and writes into log FIFO pops and TRNG FIFO pushes
`timescale 1ns/1ps

module fpga_realtime_regs
    import fpga_regs_pkg::*;
(
    input  logic              core_clk,
    input  logic              hwif_out,
    reg_bus_if.slave          bus,

    // Log FIFO side
    output logic              log_rd,
    input  logic [CHAR_W-1:0] log_char,
    input  logic              log_empty,
    input  logic              log_full,

    // TRNG FIFO side
    output logic              itrng_push,
    output itrng_word_u       itrng_word,
    output logic              itrng_reset,
    output logic [DATA_W-1:0] divisor,
    input  logic              itrng_empty,
    input  logic              itrng_full
);

    logic              wr_acc;
    logic              rd_acc;
    logic              itrng_rst_q;
    logic [DATA_W-1:0] divisor_q;
    logic [DATA_W-1:0] cycle_count;
    logic [DATA_W-1:0] rdata;
    logic              hit;

    assign wr_acc = bus.req && bus.we;
    assign rd_acc = bus.req && !bus.we;

    // Writable registers
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            itrng_rst_q <= 1'b0;
            divisor_q   <= '0;
        end else if (wr_acc) begin
            if (bus.addr == REG_CONTROL) begin
                itrng_rst_q <= bus.wdata[CTRL_ITRNG_RST_BIT];
            end
            if (bus.addr == REG_ITRNG_DIVISOR) begin
                divisor_q <= bus.wdata;
            end
        end
    end

    // Free running from reset
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Read mux and decode
    always_comb begin
        rdata = '0;
        hit   = 1'b1;
        case (bus.addr)
            REG_VERSION:       rdata = FPGA_VERSION;
            REG_CONTROL:       rdata = {{(DATA_W-1){1'b0}}, itrng_rst_q};
            REG_ITRNG_DIVISOR: rdata = divisor_q;
            REG_CYCLE_COUNT:   rdata = cycle_count;
            REG_LOG_DATA: begin
                if (!log_empty) begin  // Char only while valid
                    rdata = {{(DATA_W-CHAR_W-1){1'b0}}, 1'b1, log_char};
                end
            end
            REG_LOG_STATUS:    rdata = {{(DATA_W-2){1'b0}}, log_full, log_empty};
            REG_ITRNG_DATA:    rdata = '0;  // Write only, reads as zero
            REG_ITRNG_STATUS:  rdata = {{(DATA_W-2){1'b0}}, itrng_full, itrng_empty};
            default:           hit   = 1'b0;
        endcase
    end

    assign bus.rdata = rdata;
    assign bus.err   = !hit;

    // Pop only what the read actually returned as valid
    assign log_rd = rd_acc && (bus.addr == REG_LOG_DATA) && !log_empty;

    assign itrng_push = wr_acc && (bus.addr == REG_ITRNG_DATA);

    always_comb begin
        itrng_word.word = bus.wdata;
    end

    assign itrng_reset = itrng_rst_q;
    assign divisor     = divisor_q;

endmodule

//--- logic/fpga_wrapper_top.sv
// FPGA wrapper support logic, top level
// APB register block with cycle counter, log FIFO toward the host
// and throttled internal TRNG nibble feed toward the core
`timescale 1ns/1ps

module fpga_wrapper_top
    import fpga_regs_pkg::*;
#(
    parameter int LOG_DEPTH   = 16,
    parameter int ITRNG_DEPTH = 4
) (
    input  logic                core_clk,
    input  logic                hwif_out,
    // APB
    input  logic [ADDR_W-1:0]   paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [DATA_W-1:0]   pwdata,
    output logic [DATA_W-1:0]   prdata,
    output logic                pready,
    output logic                pslverr,
    // Log characters from the core
    input  logic                log_wr,
    input  logic [CHAR_W-1:0]   log_char,
    // TRNG
    input  logic                etrng_req,
    output logic [NIBBLE_W-1:0] itrng_data,
    output logic                itrng_valid
);

    logic              log_rd;
    logic [CHAR_W-1:0] log_head;
    logic              log_empty;
    logic              log_full;
    logic              itrng_push;
    itrng_word_u       itrng_word;
    logic              itrng_reset;
    logic [DATA_W-1:0] divisor;
    logic              itrng_empty;
    logic              itrng_full;
    logic              itrng_grant;

    reg_bus_if bus_if ();

    apb_slave_fsm apb_i (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .bus      (bus_if.master)
    );

    fpga_realtime_regs regs_i (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .bus         (bus_if.slave),
        .log_rd      (log_rd),
        .log_char    (log_head),
        .log_empty   (log_empty),
        .log_full    (log_full),
        .itrng_push  (itrng_push),
        .itrng_word  (itrng_word),
        .itrng_reset (itrng_reset),
        .divisor     (divisor),
        .itrng_empty (itrng_empty),
        .itrng_full  (itrng_full)
    );

    // Log FIFO, only cleared by reset
    sync_fifo #(
        .WIDTH (CHAR_W),
        .DEPTH (LOG_DEPTH)
    ) log_fifo_i (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .srst     (1'b0),
        .wr       (log_wr),
        .wdata    (log_char),
        .rd       (log_rd),
        .rdata    (log_head),
        .empty    (log_empty),
        .full     (log_full)
    );

    itrng_throttle throttle_i (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .req      (etrng_req),
        .divisor  (divisor),
        .grant    (itrng_grant)
    );

    itrng_fifo #(
        .DEPTH (ITRNG_DEPTH)
    ) itrng_fifo_i (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .srst         (itrng_reset),
        .push         (itrng_push),
        .word         (itrng_word),
        .grant        (itrng_grant),
        .nibble       (itrng_data),
        .nibble_valid (itrng_valid),
        .empty        (itrng_empty),
        .full         (itrng_full)
    );

endmodule

//--- tb/fpga_wrapper_asserts.sv
// Bound checks for the APB slave and the register file
// APB ready timing, single-cycle register requests, no TRNG push in reset
`timescale 1ns/1ps

module fpga_wrapper_asserts (
    input logic core_clk,
    input logic hwif_out,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic req,
    input logic itrng_push,
    input logic itrng_reset
);

    int unsigned failures = 0;  // Summed into the testbench error count

    // Ready only in an access phase that follows a setup phase
    pready_in_access: assert property (@(posedge core_clk) disable iff (!hwif_out)
        pready |-> (psel && penable && $past(psel && !penable)))
        else begin
            $error("pready high outside the APB access phase");
            failures++;
        end

    req_single_cycle: assert property (@(posedge core_clk) disable iff (!hwif_out)
        req |=> !req)
        else begin
            $error("register request held longer than one cycle");
            failures++;
        end

    no_push_in_reset: assert property (@(posedge core_clk) disable iff (!hwif_out)
        !(itrng_push && itrng_reset))
        else begin
            $error("TRNG FIFO push while its reset is set");
            failures++;
        end

endmodule

bind apb_slave_fsm fpga_wrapper_asserts apb_asserts_i (
    .core_clk    (core_clk),
    .hwif_out    (hwif_out),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .req         (phase == ACCESS),
    .itrng_push  (1'b0),
    .itrng_reset (1'b0)
);

bind fpga_realtime_regs fpga_wrapper_asserts regs_asserts_i (
    .core_clk    (core_clk),
    .hwif_out    (hwif_out),
    .psel        (1'b0),
    .penable     (1'b0),
    .pready      (1'b0),
    .req         (wr_acc || rd_acc),
    .itrng_push  (itrng_push),
    .itrng_reset (itrng_reset)
);

//--- tb/tb_fpga_wrapper.sv
// Testbench for the FPGA wrapper support logic
// Drives APB transfers, log characters and TRNG requests and checks the
// responses against a model of the register map and FIFO queues
`timescale 1ns/1ps

module tb_fpga_wrapper
    import fpga_regs_pkg::*;
();

    localparam int LOG_DEPTH      = 16;
    localparam int ITRNG_DEPTH    = 4;
    localparam int CLK_PERIOD     = 10;
    localparam int TIMEOUT_CYCLES = 4000;  // Well above the length of all tests
    localparam int DIVISOR        = 3;
    localparam logic [ADDR_W-1:0] UNMAPPED = 8'h20;
    localparam logic [31:0]       SEED     = 32'h2aef_d3cc;

    logic                core_clk;
    logic                hwif_out;
    logic [ADDR_W-1:0]   paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [DATA_W-1:0]   pwdata;
    logic [DATA_W-1:0]   prdata;
    logic                pready;
    logic                pslverr;
    logic                log_wr;
    logic [CHAR_W-1:0]   log_char;
    logic                etrng_req;
    logic [NIBBLE_W-1:0] itrng_data;
    logic                itrng_valid;

    // Reference model state
    logic [CHAR_W-1:0]   log_q[$];
    logic [NIBBLE_W-1:0] exp_nibbles[$];
    int                  itrng_words = 0;
    logic [DATA_W-1:0]   div_model   = '0;
    logic                ctrl_model  = 1'b0;

    int cycles     = 0;   // Cycles since reset release, same as the DUT counter
    int last_valid = -1;
    int checks     = 0;
    int errors     = 0;

    fpga_wrapper_top #(
        .LOG_DEPTH   (LOG_DEPTH),
        .ITRNG_DEPTH (ITRNG_DEPTH)
    ) dut_i (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .log_wr      (log_wr),
        .log_char    (log_char),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        if (hwif_out) begin
            cycles <= cycles + 1;
        end
    end

    task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got 0x%h, expected 0x%h", $time, what, got, expected);
        end
    endtask

    function automatic logic is_mapped(input logic [ADDR_W-1:0] addr);
        return addr inside {REG_VERSION, REG_CONTROL, REG_ITRNG_DIVISOR, REG_CYCLE_COUNT,
                            REG_LOG_DATA, REG_LOG_STATUS, REG_ITRNG_DATA, REG_ITRNG_STATUS};
    endfunction

    // Expected read data from the register map and the modelled queues
    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] data;
        data = '0;
        case (addr)
            REG_VERSION:       data = FPGA_VERSION;
            REG_CONTROL:       data[CTRL_ITRNG_RST_BIT] = ctrl_model;
            REG_ITRNG_DIVISOR: data = div_model;
            REG_CYCLE_COUNT:   data = DATA_W'(cycles);
            REG_LOG_DATA: begin
                if (log_q.size() != 0) begin
                    data = {{(DATA_W-CHAR_W-1){1'b0}}, 1'b1, log_q[0]};
                end
            end
            REG_LOG_STATUS:    data = {30'd0, log_q.size() == LOG_DEPTH, log_q.size() == 0};
            REG_ITRNG_STATUS:  data = {30'd0, itrng_words == ITRNG_DEPTH, itrng_words == 0};
            default:           data = '0;  // TRNG data is write only
        endcase
        return data;
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int i;
        case (addr)
            REG_CONTROL: begin
                ctrl_model = data[CTRL_ITRNG_RST_BIT];
                if (ctrl_model) begin
                    itrng_words = 0;
                    exp_nibbles.delete();
                end
            end
            REG_ITRNG_DIVISOR: div_model = data;
            REG_ITRNG_DATA: begin
                if (itrng_words < ITRNG_DEPTH) begin  // Full FIFO drops the word
                    itrng_words++;
                    for (i = 0; i < NIBBLES_PER_WORD; i++) begin
                        exp_nibbles.push_back(data[NIBBLE_W*i +: NIBBLE_W]);
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge core_clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge core_clk);
        #1;
        penable = 1'b1;
        @(negedge core_clk);
        check_value("pready on write", 32'(pready), 32'd1);
        check_value($sformatf("pslverr on write to 0x%h", addr), 32'(pslverr),
                    32'(!is_mapped(addr)));
        model_write(addr, data);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge core_clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge core_clk);
        #1;
        penable = 1'b1;
        @(negedge core_clk);  // prdata is stable mid access cycle
        data = prdata;
        check_value("pready on read", 32'(pready), 32'd1);
        check_value($sformatf("pslverr on read of 0x%h", addr), 32'(pslverr),
                    32'(!is_mapped(addr)));
        check_value($sformatf("read data of 0x%h", addr), data, expected_read(addr));
        if (addr == REG_LOG_DATA && log_q.size() != 0) begin
            void'(log_q.pop_front());
        end
    endtask

    task automatic bus_release();
        @(posedge core_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // One random character per cycle on the log port
    task automatic send_log_chars(input int count);
        logic [CHAR_W-1:0] c;
        int                i;
        for (i = 0; i < count; i++) begin
            @(posedge core_clk);
            #1;
            c        = CHAR_W'($urandom());
            log_wr   = 1'b1;
            log_char = c;
            if (log_q.size() < LOG_DEPTH) begin
                log_q.push_back(c);
            end
        end
        @(posedge core_clk);
        #1;
        log_wr = 1'b0;
    endtask

    // Nibble order and grant spacing on the TRNG port
    initial begin
        forever begin
            @(negedge core_clk);
            if (hwif_out && itrng_valid) begin
                if (exp_nibbles.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: itrng_valid pulsed with no nibble expected", $time);
                end else begin
                    check_value("itrng nibble", 32'(itrng_data), 32'(exp_nibbles.pop_front()));
                    if (exp_nibbles.size() % NIBBLES_PER_WORD == 0) begin
                        itrng_words--;  // Word popped after its last nibble
                    end
                    if (last_valid >= 0) begin
                        check_value("itrng_valid spacing", 32'(cycles - last_valid),
                                    32'(DIVISOR + 1));
                    end
                    last_valid = cycles;
                end
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) @(posedge core_clk);
        $display("ERROR: timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] first;
        void'($urandom(SEED));
        hwif_out  = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        log_wr    = 1'b0;
        log_char  = '0;
        etrng_req = 1'b0;
        repeat (3) @(posedge core_clk);
        #1;
        hwif_out = 1'b1;

        // Register map, read-only and unmapped offsets
        apb_read(REG_VERSION, rd);
        apb_write(REG_ITRNG_DIVISOR, DATA_W'(($urandom() % 15) + 1));  // Keep throttle short
        apb_read(REG_ITRNG_DIVISOR, rd);
        apb_write(REG_VERSION, 32'hdead_beef);
        apb_read(REG_VERSION, rd);
        apb_write(UNMAPPED, 32'h1234_5678);
        apb_read(UNMAPPED, rd);
        apb_read(REG_CONTROL, rd);
        apb_read(REG_LOG_STATUS, rd);
        apb_read(REG_ITRNG_STATUS, rd);

        // Back to back counter reads are one transfer apart
        apb_read(REG_CYCLE_COUNT, first);
        apb_read(REG_CYCLE_COUNT, rd);
        check_value("cycle count step", rd - first, 32'd2);
        bus_release();

        // Twenty characters in two batches that fit the log FIFO
        repeat (2) begin
            send_log_chars(10);
            repeat (10) apb_read(REG_LOG_DATA, rd);
        end
        apb_read(REG_LOG_DATA, rd);
        check_value("log valid when empty", 32'(rd[LOG_VALID_BIT]), 32'd0);
        apb_read(REG_LOG_STATUS, rd);
        bus_release();

        // Overflow keeps the oldest characters
        send_log_chars(LOG_DEPTH + 3);
        apb_read(REG_LOG_STATUS, rd);
        check_value("log full flag", 32'(rd[1]), 32'd1);
        repeat (LOG_DEPTH) apb_read(REG_LOG_DATA, rd);
        apb_read(REG_LOG_DATA, rd);
        check_value("log valid after drain", 32'(rd[LOG_VALID_BIT]), 32'd0);
        bus_release();

        // Two words handed out as sixteen throttled nibbles
        apb_write(REG_ITRNG_DIVISOR, DATA_W'(DIVISOR));
        apb_write(REG_ITRNG_DATA, $urandom());
        apb_write(REG_ITRNG_DATA, $urandom());
        apb_read(REG_ITRNG_STATUS, rd);
        bus_release();
        last_valid = -1;
        etrng_req  = 1'b1;
        while (exp_nibbles.size() != 0) @(posedge core_clk);
        #1;
        etrng_req = 1'b0;
        apb_read(REG_ITRNG_STATUS, rd);

        // Control reset empties the TRNG FIFO
        apb_write(REG_ITRNG_DATA, $urandom());
        apb_read(REG_ITRNG_STATUS, rd);
        apb_write(REG_CONTROL, 32'd1);
        apb_read(REG_ITRNG_STATUS, rd);
        check_value("itrng empty after reset", 32'(rd[0]), 32'd1);
        apb_read(REG_CONTROL, rd);
        apb_write(REG_CONTROL, 32'd0);
        bus_release();
        etrng_req = 1'b1;
        repeat (8 * (DIVISOR + 1)) @(posedge core_clk);  // Any pulse here is an error
        #1;
        etrng_req = 1'b0;

        repeat (2) @(posedge core_clk);
        errors += int'(dut_i.apb_i.apb_asserts_i.failures);
        errors += int'(dut_i.regs_i.regs_asserts_i.failures);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- fpga_wrapper_top.f
common/fpga_regs_pkg.sv
common/reg_bus_if.sv
logic/sync_fifo.sv
logic/itrng_fifo.sv
logic/itrng_throttle.sv
apb_regs/apb_slave_fsm.sv
apb_regs/fpga_realtime_regs.sv
logic/fpga_wrapper_top.sv
tb/fpga_wrapper_asserts.sv
tb/tb_fpga_wrapper.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_fpga_wrapper
FILELIST  := fpga_wrapper_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
